// ==== Makefile ====
SIM := obj_dir/Vlane_tb

SRCS := $(shell grep -v '^+' sim.f) common/lane_defines.svh

all: run

$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module lane_tb -f sim.f -o Vlane_tb

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== common/lane_defines.svh ====
// Width and depth macros for the vector lane
// Register file geometry follows from register and thread widths

`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

// Data word
`define LANE_DATA_W 32

// Registers per thread window
`define LANE_REG_BITS 4

// Thread ID selects the register window
`define LANE_THREAD_BITS 2

// Physical register index, thread above register number
`define LANE_INDEX_W (`LANE_REG_BITS + `LANE_THREAD_BITS)

// Words per bank, the index space split over even and odd banks
`define LANE_BANK_DEPTH ((1 << `LANE_INDEX_W) / 2)

`endif

// ==== common/lane_pkg.sv ====
// Opcode enum and the packed records that travel between lane stages

`include "lane_defines.svh"

package lane_pkg;

	typedef logic [`LANE_DATA_W-1:0]      lane_data_t;
	typedef logic [`LANE_REG_BITS-1:0]    lane_reg_t;
	typedef logic [`LANE_INDEX_W-1:0]     lane_idx_t;
	// Word address inside one bank, index without its bank bit
	typedef logic [`LANE_INDEX_W-2:0]     lane_addr_t;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_XOR  = 3'd3,
		OP_LDI  = 3'd4,
		OP_MOVS = 3'd5
	} lane_op_e;

	// Command from the scalar unit
	typedef struct packed {
		lane_op_e   op;
		lane_reg_t  dst;
		lane_reg_t  src1;
		lane_reg_t  src2;
		lane_data_t imm;
	} lane_cmd_t;

	// Stage 1 output, physical indices and bank selects
	typedef struct packed {
		logic       valid;
		lane_op_e   op;
		lane_data_t imm;
		lane_idx_t  dst;
		lane_addr_t src1_addr;
		logic       src1_odd;
		lane_addr_t src2_addr;
		logic       src2_odd;
	} lane_index_t;

	// Stage 2 output, operands read from the banks
	typedef struct packed {
		logic       valid;
		lane_op_e   op;
		lane_data_t imm;
		lane_idx_t  dst;
		lane_data_t src1_data;
		lane_data_t src2_data;
	} lane_operand_t;

	// Retire record, also the register file write port
	typedef struct packed {
		logic       valid;
		logic       wrote;
		lane_idx_t  index;
		lane_data_t data;
	} lane_commit_t;

endpackage

// ==== hw/cmd_capture.sv ====
// Four-phase req/ack handshake with the scalar unit
// Stage 0 command register

`timescale 1ns/1ns

`include "lane_defines.svh"

module cmd_capture
	import lane_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      cmd_req,
	input  lane_cmd_t cmd,
	output logic      cmd_ack,
	output logic      cmd_valid,
	output lane_cmd_t cmd_q
);

	logic ack_rise;

	// New request seen while ack is still low
	assign ack_rise = cmd_req & ~cmd_ack;

	////////////////////////////////////////////////////////////
	// Handshake state
	////////////////////////////////////////////////////////////

	// Ack follows req one cycle late, which gives both edges
	always_ff @(posedge clock) begin
		if (reset) begin
			cmd_ack   <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_ack   <= cmd_req;
			cmd_valid <= ack_rise;
		end
	end

	////////////////////////////////////////////////////////////
	// Command register
	////////////////////////////////////////////////////////////

	// Loaded only on the ack rise, one token per handshake
	always_ff @(posedge clock) begin
		if (ack_rise) begin
			cmd_q <= cmd;
		end
	end

endmodule

// ==== hw/exec_unit.sv ====
// Stage 3 ALU and commit register
// Commit record doubles as the register file write-back

`timescale 1ns/1ns

`include "lane_defines.svh"

module exec_unit
	import lane_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  lane_operand_t operand,
	output lane_commit_t  commit
);

	lane_data_t result;
	logic       writes_rf;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	// Add and sub wrap at the word width
	always_comb begin
		case (operand.op)
			OP_ADD: begin
				result = operand.src1_data + operand.src2_data;
			end
			OP_SUB: begin
				result = operand.src1_data - operand.src2_data;
			end
			OP_AND: begin
				result = operand.src1_data & operand.src2_data;
			end
			OP_XOR: begin
				result = operand.src1_data ^ operand.src2_data;
			end
			OP_LDI: begin
				result = operand.imm;
			end
			OP_MOVS: begin
				// Register value goes out to the scalar side
				result = operand.src1_data;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// Move-to-scalar only reports, never writes back
	assign writes_rf = (operand.op != OP_MOVS);

	////////////////////////////////////////////////////////////
	// Commit register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= operand.valid;
		end
	end

	always_ff @(posedge clock) begin
		commit.wrote <= writes_rf;
		commit.index <= operand.dst;
		commit.data  <= result;
	end

endmodule

// ==== hw/index_unit.sv ====
// Stage 1 index calculation
// Windowed physical indices and even/odd bank selects

`timescale 1ns/1ns

`include "lane_defines.svh"

module index_unit
	import lane_pkg::*;
(
	input  logic                         clock,
	input  logic                         reset,
	input  logic [`LANE_THREAD_BITS-1:0] thread_id,
	input  logic                         cmd_valid,
	input  lane_cmd_t                    cmd_q,
	output lane_index_t                  index
);

	lane_idx_t dst_idx;
	lane_idx_t src1_idx;
	lane_idx_t src2_idx;

	// Thread ID on top picks the window
	assign dst_idx  = {thread_id, cmd_q.dst};
	assign src1_idx = {thread_id, cmd_q.src1};
	assign src2_idx = {thread_id, cmd_q.src2};

	always_ff @(posedge clock) begin
		if (reset) begin
			index.valid <= 1'b0;
		end else begin
			index.valid <= cmd_valid;
		end
	end

	// Payload, bit 0 is the bank and the rest the word address
	always_ff @(posedge clock) begin
		index.op        <= cmd_q.op;
		index.imm       <= cmd_q.imm;
		index.dst       <= dst_idx;
		index.src1_addr <= src1_idx[`LANE_INDEX_W-1:1];
		index.src1_odd  <= src1_idx[0];
		index.src2_addr <= src2_idx[`LANE_INDEX_W-1:1];
		index.src2_odd  <= src2_idx[0];
	end

endmodule

// ==== hw/lane_top.sv ====
// Lane top level
// Capture, index, register read and execute stages in a row

`timescale 1ns/1ns

`include "lane_defines.svh"

module lane_top
	import lane_pkg::*;
(
	input  logic                         clock,
	input  logic                         reset,
	input  logic [`LANE_THREAD_BITS-1:0] thread_id,
	input  logic                         cmd_req,
	input  lane_cmd_t                    cmd,
	output logic                         cmd_ack,
	output lane_commit_t                 commit
);

	logic          cmd_valid;
	lane_cmd_t     cmd_q;
	lane_index_t   index;
	lane_operand_t operand;

	// Stage 0
	cmd_capture i_cmd_capture (
		.clock     (clock),
		.reset     (reset),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.cmd_valid (cmd_valid),
		.cmd_q     (cmd_q)
	);

	// Stage 1
	index_unit i_index_unit (
		.clock     (clock),
		.reset     (reset),
		.thread_id (thread_id),
		.cmd_valid (cmd_valid),
		.cmd_q     (cmd_q),
		.index     (index)
	);

	// Stage 2, written back from the commit record
	reg_file i_reg_file (
		.clock   (clock),
		.reset   (reset),
		.index   (index),
		.wb      (commit),
		.operand (operand)
	);

	// Stage 3
	exec_unit i_exec_unit (
		.clock   (clock),
		.reset   (reset),
		.operand (operand),
		.commit  (commit)
	);

endmodule

// ==== regfile/reg_bank.sv ====
// One register bank, two registered read ports and one write port

`timescale 1ns/1ns

`include "lane_defines.svh"

module reg_bank
	import lane_pkg::*;
(
	input  logic       clock,
	input  lane_addr_t rd_addr_a,
	input  lane_addr_t rd_addr_b,
	output lane_data_t rd_data_a,
	output lane_data_t rd_data_b,
	input  logic       we,
	input  lane_addr_t wr_addr,
	input  lane_data_t wr_data
);

	lane_data_t mem [`LANE_BANK_DEPTH];

	// Write port
	always_ff @(posedge clock) begin
		if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Both reads registered, data valid one cycle after the address
	always_ff @(posedge clock) begin
		rd_data_a <= mem[rd_addr_a];
		rd_data_b <= mem[rd_addr_b];
	end

endmodule

// ==== regfile/reg_file.sv ====
// Stage 2 register read over even and odd banks
// Write-back steering from the commit record

`timescale 1ns/1ns

`include "lane_defines.svh"

module reg_file
	import lane_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  lane_index_t   index,
	input  lane_commit_t  wb,
	output lane_operand_t operand
);

	lane_data_t even_a;
	lane_data_t even_b;
	lane_data_t odd_a;
	lane_data_t odd_b;
	logic       we_even;
	logic       we_odd;
	lane_addr_t wr_addr;

	// Registered alongside the bank read data
	logic       valid_q;
	lane_op_e   op_q;
	lane_data_t imm_q;
	lane_idx_t  dst_q;
	logic       src1_odd_q;
	logic       src2_odd_q;

	////////////////////////////////////////////////////////////
	// Write-back steering
	////////////////////////////////////////////////////////////

	assign wr_addr = wb.index[`LANE_INDEX_W-1:1];
	assign we_even = wb.valid & wb.wrote & ~wb.index[0];
	assign we_odd  = wb.valid & wb.wrote & wb.index[0];

	// Port a serves src1, port b serves src2
	reg_bank i_bank_even (
		.clock     (clock),
		.rd_addr_a (index.src1_addr),
		.rd_addr_b (index.src2_addr),
		.rd_data_a (even_a),
		.rd_data_b (even_b),
		.we        (we_even),
		.wr_addr   (wr_addr),
		.wr_data   (wb.data)
	);

	reg_bank i_bank_odd (
		.clock     (clock),
		.rd_addr_a (index.src1_addr),
		.rd_addr_b (index.src2_addr),
		.rd_data_a (odd_a),
		.rd_data_b (odd_b),
		.we        (we_odd),
		.wr_addr   (wr_addr),
		.wr_data   (wb.data)
	);

	////////////////////////////////////////////////////////////
	// Operand register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= index.valid;
		end
	end

	always_ff @(posedge clock) begin
		op_q       <= index.op;
		imm_q      <= index.imm;
		dst_q      <= index.dst;
		src1_odd_q <= index.src1_odd;
		src2_odd_q <= index.src2_odd;
	end

	// Pick each operand from the bank it was read from
	always_comb begin
		operand.valid     = valid_q;
		operand.op        = op_q;
		operand.imm       = imm_q;
		operand.dst       = dst_q;
		operand.src1_data = src1_odd_q ? odd_a : even_a;
		operand.src2_data = src2_odd_q ? odd_b : even_b;
	end

endmodule

// ==== sim.f ====
+incdir+common
common/lane_pkg.sv
hw/cmd_capture.sv
hw/index_unit.sv
regfile/reg_bank.sv
regfile/reg_file.sv
hw/exec_unit.sv
hw/lane_top.sv
test/lane_properties.sv
test/lane_tb.sv

// ==== test/lane_properties.sv ====
// Handshake and commit timing assertions for the lane top level

`timescale 1ns/1ns

`include "lane_defines.svh"

module lane_properties
	import lane_pkg::*;
(
	input logic         clock,
	input logic         reset,
	input logic         cmd_req,
	input logic         cmd_ack,
	input lane_commit_t commit
);

	logic       ack_q;
	logic       ack_rose;
	logic       ack_fell;
	logic [2:0] rise_pipe;
	int         failures = 0;

	assign ack_rose = cmd_ack & ~ack_q;
	assign ack_fell = ~cmd_ack & ack_q;

	// Ack rise delayed by the three pipeline stages after capture
	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q     <= 1'b0;
			rise_pipe <= '0;
		end else begin
			ack_q     <= cmd_ack;
			rise_pipe <= {rise_pipe[1:0], ack_rose};
		end
	end

	////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////

	a_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		ack_rose |-> $past(cmd_req)) else begin
		$error("cmd_ack rose without cmd_req");
		failures++;
	end

	a_ack_falls_after_req: assert property (@(posedge clock) disable iff (reset)
		ack_fell |-> !$past(cmd_req)) else begin
		$error("cmd_ack fell while cmd_req was high");
		failures++;
	end

	////////////////////////////////////////////////////////////
	// Commit
	////////////////////////////////////////////////////////////

	a_commit_one_cycle: assert property (@(posedge clock) disable iff (reset)
		commit.valid |=> !commit.valid) else begin
		$error("commit.valid held longer than one cycle");
		failures++;
	end

	a_commit_latency: assert property (@(posedge clock) disable iff (reset)
		commit.valid == rise_pipe[2]) else begin
		$error("commit.valid not 3 cycles after the ack rise");
		failures++;
	end

endmodule

bind lane_top lane_properties i_props (
	.clock   (clock),
	.reset   (reset),
	.cmd_req (cmd_req),
	.cmd_ack (cmd_ack),
	.commit  (commit)
);

// ==== test/lane_tb.sv ====
// Lane testbench with clock, reset, LFSR and register model
// Directed tests for handshake, load, ALU, thread windows and a random run

`timescale 1ns/1ns

`include "lane_defines.svh"

module lane_tb
	import lane_pkg::*;
();

	localparam int WAIT_LIMIT = 16;

	logic                         clock;
	logic                         reset;
	logic [`LANE_THREAD_BITS-1:0] thread_id;
	logic                         cmd_req;
	lane_cmd_t                    cmd;
	logic                         cmd_ack;
	lane_commit_t                 commit;

	int           cycle_count;
	logic [31:0]  lfsr_state;
	lane_data_t   reg_model [1 << `LANE_THREAD_BITS][1 << `LANE_REG_BITS];
	lane_commit_t commit_q [$];
	int           commit_cycle_q [$];
	int           rise_delay;
	int           fall_delay;
	int           commit_delay;

	lane_top i_dut (
		.clock     (clock),
		.reset     (reset),
		.thread_id (thread_id),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.commit    (commit)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	always @(posedge clock) begin
		if (reset) begin
			cycle_count <= 0;
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	// Collect retire records with the cycle they showed up in
	always @(negedge clock) begin
		if (!reset && commit.valid === 1'b1) begin
			commit_q.push_back(commit);
			commit_cycle_q.push_back(cycle_count);
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[31]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1, "Stopped on timeout");
	endtask

	// Four-phase handshake, req held for extra cycles after ack, then the commit
	task automatic issue_cmd(input logic [`LANE_THREAD_BITS-1:0] tid, input lane_cmd_t c,
		input int hold, output lane_commit_t rec);
		int waited;
		int req_cycle;
		int ack_cycle;
		int drop_cycle;
		check_value("stray commits", commit_q.size(), 0);
		@(posedge clock);
		thread_id <= tid;
		cmd       <= c;
		cmd_req   <= 1'b1;
		@(negedge clock);
		req_cycle = cycle_count;
		waited = 0;
		while (cmd_ack !== 1'b1 && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (cmd_ack !== 1'b1) report_timeout("cmd_ack to rise");
		ack_cycle  = cycle_count;
		rise_delay = ack_cycle - req_cycle;
		repeat (hold) begin
			@(negedge clock);
			check_value("cmd_ack while req held", 32'(cmd_ack), 32'd1);
		end
		@(posedge clock);
		cmd_req <= 1'b0;
		@(negedge clock);
		drop_cycle = cycle_count;
		waited = 0;
		while (cmd_ack !== 1'b0 && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (cmd_ack !== 1'b0) report_timeout("cmd_ack to fall");
		fall_delay = cycle_count - drop_cycle;
		waited = 0;
		while (commit_q.size() == 0 && waited < WAIT_LIMIT) begin
			@(posedge clock);
			waited++;
		end
		if (commit_q.size() == 0) report_timeout("the commit record");
		rec = commit_q.pop_front();
		commit_delay = commit_cycle_q.pop_front() - ack_cycle;
	endtask

	// One command checked against the model, which then takes the write
	task automatic run_checked(input logic [`LANE_THREAD_BITS-1:0] tid, input lane_op_e op,
		input lane_reg_t dst, input lane_reg_t src1, input lane_reg_t src2,
		input lane_data_t imm, input int hold);
		lane_cmd_t    c;
		lane_commit_t rec;
		lane_data_t   a;
		lane_data_t   b;
		lane_data_t   expected;
		c = '{op: op, dst: dst, src1: src1, src2: src2, imm: imm};
		a = reg_model[tid][src1];
		b = reg_model[tid][src2];
		case (op)
			OP_ADD:  expected = a + b;
			OP_SUB:  expected = a - b;
			OP_AND:  expected = a & b;
			OP_XOR:  expected = a ^ b;
			OP_MOVS: expected = a;
			default: expected = imm;
		endcase
		issue_cmd(tid, c, hold, rec);
		check_value("commit.valid", 32'(rec.valid), 32'd1);
		check_value("commit.wrote", 32'(rec.wrote), 32'(op != OP_MOVS));
		check_value("commit.index", 32'(rec.index), 32'({tid, dst}));
		check_value("commit.data", rec.data, expected);
		check_value("cmd_ack rise delay", rise_delay, 32'd1);
		check_value("cmd_ack fall delay", fall_delay, 32'd1);
		check_value("commit delay", commit_delay, 32'd3);
		if (op != OP_MOVS) reg_model[tid][dst] = expected;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_handshake();
		repeat (4) begin
			@(negedge clock);
			check_value("cmd_ack after reset", 32'(cmd_ack), 32'd0);
			check_value("commit.valid after reset", 32'(commit.valid), 32'd0);
		end
		run_checked(2'd2, OP_LDI, 4'd1, 4'd0, 4'd0, 32'hcafe_0001, 0);
		run_checked(2'd2, OP_LDI, 4'd14, 4'd0, 4'd0, 32'hcafe_0002, 3);
	endtask

	task automatic test_load_immediate();
		run_checked(2'd0, OP_LDI, 4'd3, 4'd0, 4'd0, 32'h1234_5678, 0);
		run_checked(2'd0, OP_LDI, 4'd9, 4'd0, 4'd0, 32'h9abc_def0, 0);
		// Move with dst 3 must leave r3 alone
		run_checked(2'd0, OP_MOVS, 4'd3, 4'd9, 4'd0, 32'hffff_ffff, 0);
		run_checked(2'd0, OP_MOVS, 4'd0, 4'd3, 4'd0, 32'h0, 0);
	endtask

	task automatic test_alu_ops();
		lane_op_e  ops [4] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
		lane_reg_t src_a [4] = '{4'd2, 4'd5, 4'd5, 4'd4};
		lane_reg_t src_b [4] = '{4'd4, 4'd7, 4'd2, 4'd4};
		run_checked(2'd1, OP_LDI, 4'd2, 4'd0, 4'd0, 32'hffff_fff0, 0);
		run_checked(2'd1, OP_LDI, 4'd4, 4'd0, 4'd0, 32'h0000_0025, 0);
		run_checked(2'd1, OP_LDI, 4'd5, 4'd0, 4'd0, 32'h8000_0001, 0);
		run_checked(2'd1, OP_LDI, 4'd7, 4'd0, 4'd0, 32'h7fff_ffff, 0);
		// Pairs cover even/even, odd/odd, odd/even and src1 equal to src2
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				run_checked(2'd1, ops[i], 4'(8 + j), src_a[j], src_b[j], 32'h0, 0);
			end
		end
	endtask

	task automatic test_thread_windows();
		for (int t = 0; t < 4; t++) begin
			run_checked(2'(t), OP_LDI, 4'd6, 4'd0, 4'd0, 32'h0600_0000 + 32'(t) * 32'h0101, 0);
		end
		for (int t = 0; t < 4; t++) begin
			run_checked(2'(t), OP_MOVS, 4'd0, 4'd6, 4'd0, 32'h0, 0);
		end
	endtask

	task automatic test_random();
		logic [31:0] v;
		logic [31:0] t;
		logic [31:0] d;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] imm;
		// Every register gets a known value before random reads
		for (int th = 0; th < 4; th++) begin
			for (int r = 0; r < 16; r++) begin
				random_bits(32, v);
				run_checked(2'(th), OP_LDI, 4'(r), 4'd0, 4'd0, v, 0);
			end
		end
		repeat (40) begin
			random_bits(3, v);
			random_bits(2, t);
			random_bits(4, d);
			random_bits(4, s1);
			random_bits(4, s2);
			random_bits(32, imm);
			run_checked(t[1:0], lane_op_e'(3'(v % 6)), d[3:0], s1[3:0], s2[3:0], imm, 0);
		end
	endtask

	initial begin
		reset      <= 1'b1;
		thread_id  <= '0;
		cmd_req    <= 1'b0;
		cmd        <= '0;
		lfsr_state = 32'ha8dc;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		test_handshake();
		test_load_immediate();
		test_alu_ops();
		test_thread_windows();
		test_random();
		repeat (4) @(posedge clock);
		if (i_dut.i_props.failures != 0) begin
			$display("Assertion failures seen: %0d", i_dut.i_props.failures);
			$display("TEST FAILED");
			$fatal(1, "Assertions failed");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule
